// File: include/exec_consts.svh
`ifndef EXEC_CONSTS_SVH
`define EXEC_CONSTS_SVH

// Operand and address width
`define DATA_W 32

// Number of architectural flags kept
`define FLAG_W 5

// Bit positions inside the flag vector
`define FLAG_CF 0
`define FLAG_ZF 1
`define FLAG_SF 2
`define FLAG_OF 3
`define FLAG_DF 4

// All flags clear out of reset so strings count up
`define FLAGS_RESET 5'b00000

`endif

// File: source/exec_pkg.sv
`default_nettype none

`include "exec_consts.svh"

package exec_pkg;

    typedef logic [`DATA_W-1:0] data_t;  // Operand, result or address
    typedef logic [`FLAG_W-1:0] flags_t; // CF ZF SF OF DF
    typedef logic [1:0]         opsize_t; // 0 byte, 1 word, 2 dword

    // Decoded operation kind from issue
    typedef enum logic [3:0] {
        OP_NOP, OP_ADD, OP_AND, OP_OR,
        OP_NOT, OP_SAL, OP_SAR, OP_MOVS,
        OP_PUSH, OP_POP, OP_JMP, OP_JCC,
        OP_CLD, OP_STD
    } op_kind_t;

    // Jcc conditions
    typedef enum logic [1:0] {
        COND_Z,  // JZ / JE
        COND_NZ, // JNZ / JNE
        COND_C,  // JC / JB
        COND_NC  // JNC / JAE
    } cond_t;

endpackage

`default_nettype wire

// File: source/operand_latch.sv
`timescale 1ns/1ps
`default_nettype none

module operand_latch (
    input  wire                    clk,
    input  wire                    arst_n,
    input  wire                    valid_in,
    input  wire                    stall,
    input  wire exec_pkg::op_kind_t op_in,
    input  wire exec_pkg::opsize_t size_in,
    input  wire exec_pkg::cond_t   cond_in,
    input  wire exec_pkg::data_t   op1_in,
    input  wire exec_pkg::data_t   op2_in,
    input  wire exec_pkg::data_t   op3_in,
    input  wire exec_pkg::data_t   op4_in,
    input  wire                    pred_taken_in,
    input  wire exec_pkg::data_t   pred_target_in,
    output wire                    valid_out,
    output exec_pkg::op_kind_t     op_q,
    output exec_pkg::opsize_t      size_q,
    output exec_pkg::cond_t        cond_q,
    output exec_pkg::data_t        op1_q,
    output exec_pkg::data_t        op2_q,
    output exec_pkg::data_t        op3_q,
    output exec_pkg::data_t        op4_q,
    output logic                   pred_taken_q,
    output exec_pkg::data_t        pred_target_q
);
    import exec_pkg::*;

    logic full; // Latch holds a bundle

    // Op kind is reset so the units see a NOP out of reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            full <= 1'b0;
            op_q <= OP_NOP;
        end else if (!stall) begin
            full <= valid_in; // Retire current, take next or go empty
            if (valid_in) op_q <= op_in;
        end
    end

    // Payload only moves on capture
    always_ff @(posedge clk) begin
        if (valid_in && !stall) begin
            size_q        <= size_in;
            cond_q        <= cond_in;
            op1_q         <= op1_in;
            op2_q         <= op2_in;
            op3_q         <= op3_in;
            op4_q         <= op4_in;
            pred_taken_q  <= pred_taken_in;
            pred_target_q <= pred_target_in;
        end
    end

    assign valid_out = full & ~stall;

    // A retiring bundle was captured earlier and held since
    a_no_retire_when_empty: assert property (@(posedge clk) disable iff (!arst_n)
        valid_out |-> ($past(valid_in && !stall) || $past(full && stall)));
    // A stalled bundle stays put until the stall drops
    a_hold_under_stall: assert property (@(posedge clk) disable iff (!arst_n)
        (full && stall) |=> (full && $stable(op_q) && $stable(op1_q)));

endmodule

`default_nettype wire

// File: source/alu_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_consts.svh"

module alu_core (
    input  wire exec_pkg::op_kind_t op,
    input  wire exec_pkg::data_t    op1,
    input  wire exec_pkg::data_t    op2,
    input  wire exec_pkg::flags_t   flags_in,
    output exec_pkg::data_t         res1,
    output exec_pkg::flags_t        flags_next,
    output exec_pkg::flags_t        flags_mask
);
    import exec_pkg::*;

    logic [`DATA_W:0] add_sum;   // Carry in the top bit
    logic             add_ovf;
    logic [4:0]       shamt;
    logic [`DATA_W:0] sal_wide;  // Top bit is the last bit shifted out
    logic [`DATA_W:0] sar_wide;  // Bottom bit is the last bit shifted out

    assign add_sum = {1'b0, op1} + {1'b0, op2};
    // Same sign in, different sign out
    assign add_ovf = (op1[`DATA_W-1] == op2[`DATA_W-1]) &&
                     (add_sum[`DATA_W-1] != op1[`DATA_W-1]);

    assign shamt    = op2[4:0];
    assign sal_wide = {1'b0, op1} << shamt;
    assign sar_wide = $signed({op1, 1'b0}) >>> shamt;

    always_comb begin
        res1       = op1;
        flags_next = flags_in;
        flags_mask = '0;
        case (op)
            OP_ADD: begin
                res1                   = add_sum[`DATA_W-1:0];
                flags_next[`FLAG_CF]   = add_sum[`DATA_W];
                flags_next[`FLAG_OF]   = add_ovf;
                flags_mask[`FLAG_CF]   = 1'b1;
                flags_mask[`FLAG_OF]   = 1'b1;
                flags_mask[`FLAG_ZF]   = 1'b1;
                flags_mask[`FLAG_SF]   = 1'b1;
            end
            OP_AND, OP_OR: begin
                res1 = (op == OP_AND) ? (op1 & op2) : (op1 | op2);
                flags_next[`FLAG_CF] = 1'b0; // Logic ops clear CF and OF
                flags_next[`FLAG_OF] = 1'b0;
                flags_mask[`FLAG_CF] = 1'b1;
                flags_mask[`FLAG_OF] = 1'b1;
                flags_mask[`FLAG_ZF] = 1'b1;
                flags_mask[`FLAG_SF] = 1'b1;
            end
            OP_NOT: res1 = ~op1; // No flags touched
            OP_SAL, OP_SAR: begin
                res1 = (op == OP_SAL) ? sal_wide[`DATA_W-1:0] : sar_wide[`DATA_W:1];
                flags_next[`FLAG_CF] = (op == OP_SAL) ? sal_wide[`DATA_W] : sar_wide[0];
                flags_next[`FLAG_OF] = 1'b0;
                flags_mask[`FLAG_CF] = 1'b1;
                flags_mask[`FLAG_OF] = 1'b1;
                flags_mask[`FLAG_ZF] = 1'b1;
                flags_mask[`FLAG_SF] = 1'b1;
            end
            OP_CLD, OP_STD: begin
                flags_next[`FLAG_DF] = (op == OP_STD);
                flags_mask[`FLAG_DF] = 1'b1;
            end
            default: ;
        endcase
        // Result based flags
        if (flags_mask[`FLAG_ZF]) flags_next[`FLAG_ZF] = (res1 == '0);
        if (flags_mask[`FLAG_SF]) flags_next[`FLAG_SF] = res1[`DATA_W-1];
    end

endmodule

`default_nettype wire

// File: source/ptr_adjust.sv
`timescale 1ns/1ps
`default_nettype none

module ptr_adjust (
    input  wire exec_pkg::op_kind_t op,
    input  wire exec_pkg::opsize_t  size,
    input  wire                     df,
    input  wire exec_pkg::data_t    op3,  // ESI
    input  wire exec_pkg::data_t    op4,  // EDI or ESP
    output exec_pkg::data_t         res3,
    output exec_pkg::data_t         res4
);
    import exec_pkg::*;

    data_t step;
    data_t op3_up;
    data_t op3_down;
    data_t op4_up;
    data_t op4_down;

    // Bytes per element
    always_comb begin
        case (size)
            2'd0:    step = 32'd1;
            2'd1:    step = 32'd2;
            default: step = 32'd4; // dword
        endcase
    end

    assign op3_up   = op3 + step;
    assign op3_down = op3 - step;
    assign op4_up   = op4 + step;
    assign op4_down = op4 - step;

    always_comb begin
        res3 = op3;
        res4 = op4;
        case (op)
            OP_MOVS: begin
                // DF picks the string direction for both pointers
                res3 = df ? op3_down : op3_up;
                res4 = df ? op4_down : op4_up;
            end
            OP_PUSH: res4 = op4_down; // Stack grows down
            OP_POP:  res4 = op4_up;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: source/eflags_reg.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_consts.svh"

module eflags_reg (
    input  wire                   clk,
    input  wire                   arst_n,
    input  wire                   write,       // Op retires this cycle
    input  wire exec_pkg::flags_t flags_next,
    input  wire exec_pkg::flags_t flags_mask,
    output exec_pkg::flags_t      eflags
);
    import exec_pkg::*;

    flags_t flags_merged;

    // Masked bits take the new value, the rest keep theirs
    assign flags_merged = (eflags & ~flags_mask) | (flags_next & flags_mask);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            eflags <= `FLAGS_RESET;
        end else if (write) begin
            eflags <= flags_merged;
        end
    end

    a_hold_without_write: assert property (@(posedge clk) disable iff (!arst_n)
        !write |=> $stable(eflags));

endmodule

`default_nettype wire

// File: source/branch_resolve.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_consts.svh"

module branch_resolve (
    input  wire                     valid,       // Retiring this cycle
    input  wire exec_pkg::op_kind_t op,
    input  wire exec_pkg::cond_t    cond,
    input  wire exec_pkg::flags_t   eflags,      // Committed flags
    input  wire exec_pkg::data_t    op2,         // Branch target
    input  wire                     pred_taken,
    input  wire exec_pkg::data_t    pred_target,
    output wire                     br_valid,
    output wire                     br_taken,
    output wire                     br_correct,
    output exec_pkg::data_t         br_fip
);
    import exec_pkg::*;

    logic is_jmp;
    logic is_jcc;
    logic cond_hold;
    logic dir_ok;
    logic target_ok;

    assign is_jmp = (op == OP_JMP);
    assign is_jcc = (op == OP_JCC);

    always_comb begin
        case (cond)
            COND_Z:  cond_hold = eflags[`FLAG_ZF];
            COND_NZ: cond_hold = ~eflags[`FLAG_ZF];
            COND_C:  cond_hold = eflags[`FLAG_CF];
            default: cond_hold = ~eflags[`FLAG_CF]; // COND_NC
        endcase
    end

    assign br_valid = valid & (is_jmp | is_jcc);
    assign br_taken = br_valid & (is_jmp | (is_jcc & cond_hold));

    // Fetch redirect is zero when falling through
    assign br_fip = br_taken ? op2 : '0;

    assign dir_ok     = (pred_taken == br_taken);
    assign target_ok  = (pred_target == op2);
    // Target only matters on the taken path
    assign br_correct = br_valid & dir_ok & (~br_taken | target_ok);

endmodule

`default_nettype wire

// File: source/execute_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_consts.svh"

module execute_top (
    input  wire                     clk,
    input  wire                     arst_n,
    input  wire                     valid_in,
    input  wire                     stall,
    input  wire exec_pkg::op_kind_t op,
    input  wire exec_pkg::opsize_t  size,
    input  wire exec_pkg::cond_t    cond,
    input  wire exec_pkg::data_t    op1,
    input  wire exec_pkg::data_t    op2,
    input  wire exec_pkg::data_t    op3,
    input  wire exec_pkg::data_t    op4,
    input  wire                     pred_taken,
    input  wire exec_pkg::data_t    pred_target,
    output wire                     valid_out,
    output exec_pkg::data_t         res1,
    output exec_pkg::data_t         res3,
    output exec_pkg::data_t         res4,
    output exec_pkg::flags_t        eflags,
    output wire                     br_valid,
    output wire                     br_taken,
    output wire                     br_correct,
    output exec_pkg::data_t         br_fip
);
    import exec_pkg::*;

    op_kind_t op_q;
    opsize_t  size_q;
    cond_t    cond_q;
    data_t    op1_q, op2_q, op3_q, op4_q;
    data_t    pred_target_q;
    logic     pred_taken_q;
    flags_t   flags_next, flags_mask;

    operand_latch u_latch (.clk, .arst_n, .valid_in, .stall, .op_in(op), .size_in(size),
        .cond_in(cond), .op1_in(op1), .op2_in(op2), .op3_in(op3), .op4_in(op4),
        .pred_taken_in(pred_taken), .pred_target_in(pred_target), .valid_out, .op_q,
        .size_q, .cond_q, .op1_q, .op2_q, .op3_q, .op4_q, .pred_taken_q, .pred_target_q);

    alu_core u_alu (.op(op_q), .op1(op1_q), .op2(op2_q), .flags_in(eflags), .res1,
        .flags_next, .flags_mask);

    // String direction comes from the committed DF
    ptr_adjust u_ptr (.op(op_q), .size(size_q), .df(eflags[`FLAG_DF]), .op3(op3_q),
        .op4(op4_q), .res3, .res4);

    eflags_reg u_flags (.clk, .arst_n, .write(valid_out), .flags_next, .flags_mask, .eflags);

    branch_resolve u_branch (.valid(valid_out), .op(op_q), .cond(cond_q), .eflags,
        .op2(op2_q), .pred_taken(pred_taken_q), .pred_target(pred_target_q), .br_valid,
        .br_taken, .br_correct, .br_fip);

endmodule

`default_nettype wire

// File: bench/tb_execute.sv
`timescale 1ns/1ps
`default_nettype none

module tb_execute;
    import exec_pkg::*;

    localparam int SAMPLE_DELAY = 4; // 1 ns before the rising edge

    typedef struct {
        string      name;
        logic [3:0] op;
        logic [1:0] size;
        logic [1:0] cond;
        data_t      op1, op2, op3, op4;
        logic       pred_taken;
        data_t      pred_target;
        int         stall_cycles;
        data_t      exp_res1, exp_res3, exp_res4;
        flags_t     exp_flags;
        logic       exp_taken, exp_correct;
    } test_t;

    logic     clk, arst_n, valid_in, stall, pred_taken;
    op_kind_t op;
    opsize_t  size;
    cond_t    cond;
    data_t    op1, op2, op3, op4, pred_target;
    logic     valid_out, br_valid, br_taken, br_correct;
    data_t    res1, res3, res4, br_fip;
    flags_t   eflags;

    test_t      tests[$];
    int         test_errs[64];     // Slot 0 is the reset check
    int         pending = -1;      // Test whose flags commit next
    int         pass_count = 0;
    int         fail_count = 0;
    int         load_errs = 0;
    int         cycles = 0;
    int         cycle_limit = 0;
    logic [7:0] lfsr = 8'd5;

    execute_top u_dut (.clk, .arst_n, .valid_in, .stall, .op, .size, .cond, .op1, .op2, .op3,
        .op4, .pred_taken, .pred_target, .valid_out, .res1, .res3, .res4, .eflags, .br_valid,
        .br_taken, .br_correct, .br_fip);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Run length guard
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("run stopped after %0d cycles, limit reached", cycles);
            $display("TEST FAIL");
            $finish;
        end
    end

    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]}; // x^8+x^6+x^5+x^4+1
    endfunction

    // Two fresh bits give 0 to 3 idle cycles
    function automatic int pick_idle();
        int n;
        n = 0;
        repeat (2) begin
            lfsr = lfsr_next(lfsr);
            n = n * 2 + int'(lfsr[0]);
        end
        return n;
    endfunction

    task automatic compare(input int slot, input string sig, input logic [31:0] got,
                           input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, sig, got, exp);
            test_errs[slot]++;
        end
    endtask

    task automatic report_test(input int slot, input string name);
        if (test_errs[slot] == 0) begin
            pass_count++;
            $display("%-12s ok", name);
        end else begin
            fail_count++;
            $display("%-12s FAILED with %0d errors", name, test_errs[slot]);
        end
    endtask

    task automatic load_tests();
        int    fd;
        int    code;
        string line;
        test_t t;
        fd = $fopen("bench/testdata_execute.txt", "r");
        if (fd == 0) begin
            $display("cannot open bench/testdata_execute.txt");
            load_errs++;
            return;
        end
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code == 0 || line.len() < 2 || line.getc(0) == "#") continue;
            code = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h", t.name,
                t.op, t.size, t.cond, t.op1, t.op2, t.op3, t.op4, t.pred_taken, t.pred_target,
                t.stall_cycles, t.exp_res1, t.exp_res3, t.exp_res4, t.exp_flags, t.exp_taken,
                t.exp_correct);
            if (code == 17) tests.push_back(t);
            else begin
                $display("malformed line in test data: %s", line);
                load_errs++;
            end
        end
        $fclose(fd);
        if (tests.size() == 0) begin
            $display("test data holds no tests");
            load_errs++;
        end
    endtask

    task automatic drive(input int i);
        valid_in    = 1'b1;
        stall       = 1'b0;
        op          = op_kind_t'(tests[i].op);
        size        = tests[i].size;
        cond        = cond_t'(tests[i].cond);
        op1         = tests[i].op1;
        op2         = tests[i].op2;
        op3         = tests[i].op3;
        op4         = tests[i].op4;
        pred_taken  = tests[i].pred_taken;
        pred_target = tests[i].pred_target;
    endtask

    // Flags of the last retired op are committed by now
    task automatic check_pending();
        if (pending >= 0) begin
            compare(pending + 1, "eflags", 32'(eflags), 32'(tests[pending].exp_flags));
            report_test(pending + 1, tests[pending].name);
            pending = -1;
        end
    endtask

    // Entered on the falling edge where test i was driven
    task automatic run_test(input int i, output int idle);
        flags_t held;
        int     waited;
        logic   is_branch;
        @(negedge clk);
        check_pending();
        valid_in = 1'b0;
        if (tests[i].stall_cycles > 0) begin
            stall = 1'b1;
            held  = eflags;
            repeat (tests[i].stall_cycles) begin
                #SAMPLE_DELAY;
                compare(i + 1, "valid_out", 32'(valid_out), 32'd0);
                compare(i + 1, "eflags", 32'(eflags), 32'(held));
                @(negedge clk);
            end
            compare(i + 1, "eflags", 32'(eflags), 32'(held));
            stall = 1'b0;
        end
        idle = (i + 1 < tests.size()) ? pick_idle() : 1;
        if (idle == 0) drive(i + 1); // Next op lands right behind this one
        #SAMPLE_DELAY;
        waited = 0;
        while (!valid_out && waited < 8) begin
            @(negedge clk);
            #SAMPLE_DELAY;
            waited++;
        end
        if (!valid_out) begin
            $display("%s: valid_out never rose within 8 cycles after the stall", tests[i].name);
            test_errs[i + 1]++;
        end else begin
            is_branch = op_kind_t'(tests[i].op) inside {OP_JMP, OP_JCC};
            compare(i + 1, "res1", res1, tests[i].exp_res1);
            compare(i + 1, "res3", res3, tests[i].exp_res3);
            compare(i + 1, "res4", res4, tests[i].exp_res4);
            compare(i + 1, "br_valid", 32'(br_valid), 32'(is_branch));
            compare(i + 1, "br_taken", 32'(br_taken), 32'(tests[i].exp_taken));
            compare(i + 1, "br_correct", 32'(br_correct), 32'(tests[i].exp_correct));
            compare(i + 1, "br_fip", br_fip, tests[i].exp_taken ? tests[i].op2 : '0);
        end
        pending = i;
    endtask

    initial begin
        int idle;
        arst_n = 1'b0;
        valid_in = 1'b0;
        stall = 1'b0;
        op = OP_NOP;
        size = '0;
        cond = COND_Z;
        op1 = '0;
        op2 = '0;
        op3 = '0;
        op4 = '0;
        pred_taken = 1'b0;
        pred_target = '0;
        load_tests();
        cycle_limit = 12 * tests.size() + 20;
        repeat (2) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        compare(0, "valid_out", 32'(valid_out), 32'd0);
        compare(0, "br_valid", 32'(br_valid), 32'd0);
        compare(0, "eflags", 32'(eflags), 32'd0);
        report_test(0, "reset");
        if (tests.size() > 0) drive(0);
        for (int i = 0; i < tests.size(); i++) begin
            run_test(i, idle);
            repeat (idle) begin
                @(negedge clk);
                check_pending();
            end
            if (idle > 0 && i + 1 < tests.size()) drive(i + 1);
        end
        $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
        if (fail_count == 0 && load_errs == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+include
source/exec_pkg.sv
source/operand_latch.sv
source/alu_core.sv
source/ptr_adjust.sv
source/eflags_reg.sv
source/branch_resolve.sv
source/execute_top.sv
bench/tb_execute.sv

// File: run.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_execute -Mdir obj_dir -f flist.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_execute)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST PASS"; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1

// File: bench/testdata_execute.txt
# name op size cond op1 op2 op3 op4 pred_taken pred_target stall res1 res3 res4 eflags taken correct
# all fields hex, op and cond codes in exec_pkg enum order, eflags bits DF OF SF ZF CF
add_carry 1 2 0 ffffffff 00000001 00001000 00002000 0 00000000 0 00000000 00001000 00002000 03 0 0
add_ovf   1 2 0 7fffffff 00000001 00001000 00002000 0 00000000 2 80000000 00001000 00002000 0c 0 0
and_zero  2 2 0 f0f0f0f0 0f0f0f0f 00001000 00002000 0 00000000 0 00000000 00001000 00002000 02 0 0
or_sign   3 2 0 80000000 00000001 00001000 00002000 0 00000000 0 80000001 00001000 00002000 04 0 0
not_op    4 2 0 12345678 00000000 00001000 00002000 0 00000000 1 edcba987 00001000 00002000 04 0 0
sal_zero  5 2 0 80000001 00000000 00001000 00002000 0 00000000 0 80000001 00001000 00002000 04 0 0
sal_one   5 2 0 c0000001 00000021 00001000 00002000 0 00000000 0 80000002 00001000 00002000 05 0 0
sar_zero  6 2 0 80000000 00000000 00001000 00002000 0 00000000 0 80000000 00001000 00002000 04 0 0
sar_five  6 2 0 80000010 00000005 00001000 00002000 0 00000000 0 fc000000 00001000 00002000 05 0 0
push_b    8 0 0 00000000 00000000 00001000 00002000 0 00000000 0 00000000 00001000 00001fff 05 0 0
push_w    8 1 0 00000000 00000000 00001000 00002000 0 00000000 0 00000000 00001000 00001ffe 05 0 0
push_d    8 2 0 00000000 00000000 00001000 00002000 0 00000000 1 00000000 00001000 00001ffc 05 0 0
pop_b     9 0 0 00000000 00000000 00001000 00002000 0 00000000 0 00000000 00001000 00002001 05 0 0
pop_w     9 1 0 00000000 00000000 00001000 00002000 0 00000000 0 00000000 00001000 00002002 05 0 0
pop_d     9 2 0 00000000 00000000 00001000 00002000 0 00000000 0 00000000 00001000 00002004 05 0 0
movs_up   7 2 0 00000000 00000000 00001000 00002000 0 00000000 0 00000000 00001004 00002004 05 0 0
std_op    d 2 0 00000000 00000000 00001000 00002000 0 00000000 0 00000000 00001000 00002000 15 0 0
movs_down 7 1 0 00000000 00000000 00001000 00002000 0 00000000 2 00000000 00000ffe 00001ffe 15 0 0
cld_op    c 2 0 00000000 00000000 00001000 00002000 0 00000000 0 00000000 00001000 00002000 05 0 0
jnz_ok    b 2 1 00000000 00004000 00001000 00002000 1 00004000 0 00000000 00001000 00002000 05 1 1
jc_badtgt b 2 2 00000000 00004000 00001000 00002000 1 00004010 0 00000000 00001000 00002000 05 1 0
add_zero  1 2 0 ffffffff 00000001 00001000 00002000 0 00000000 3 00000000 00001000 00002000 03 0 0
jz_baddir b 2 0 00000000 00005000 00001000 00002000 0 00005000 0 00000000 00001000 00002000 03 1 0
jnc_ok    b 2 3 00000000 00005000 00001000 00002000 0 00000000 0 00000000 00001000 00002000 03 0 1
jmp_ok    a 2 0 00000000 00006000 00001000 00002000 1 00006000 0 00000000 00001000 00002000 03 1 1
